// ==== vlog.f ====
verilog/nn_pkg.sv
verilog/weight_store.sv
verilog/layer_decode.sv
verilog/dot_execute.sv
verilog/activation_result.sv
verilog/nn_top.sv
verification/nn_chk.sv
verification/nn_tb.sv

// ==== verification/nn_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module nn_tb;

	import nn_pkg::*;

	localparam int PERIOD = 40;
	localparam int N_TESTS = 6;
	localparam int TEST_CYCLES = 400;

	logic clk = 1'b0;
	logic reset;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic start;
	sample_t sample;
	logic busy;
	logic done;
	scores_t scores;

	// host copy of the weight bank
	weight_t wref [N_WEIGHTS];
	int errors = 0;

	nn_top nn_top_i (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.start(start),
		.sample(sample),
		.busy(busy),
		.done(done),
		.scores(scores)
	);

	bind nn_top nn_chk nn_chk_i (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.start(start),
		.busy(busy),
		.done(done)
	);

	always #(PERIOD / 2) clk = ~clk;

	initial begin : watchdog
		#(N_TESTS * TEST_CYCLES * PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", N_TESTS * TEST_CYCLES);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

	always @(negedge clk) begin
		if (nn_top_i.nn_chk_i.fail_count != 0) begin
			$display("a handshake or done timing assertion in the checker failed");
			$display("TB FAILED");
			$fatal(1, "assertion failure");
		end
	end

	task automatic report_error(input string msg);
		errors++;
		$display("Fail at %0t ns: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input wb_dat_t got, input wb_dat_t exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s: got %h, expected %h", what, got, exp));
		end
	endtask

	task automatic check_scores(input scores_t got, input scores_t exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s: got %0d/%0d, expected %0d/%0d", what,
				got.score0, got.score1, exp.score0, exp.score1));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s: got %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_value(input int got, input int exp, input string what);
		if (got != exp) begin
			report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
		end
	endtask

	// one classic cycle, stb dropped after the ack
	task automatic wb_transfer(input logic we, input wb_adr_t adr, input wb_dat_t dat,
			output wb_dat_t rdata);
		int waited;
		wb_req_t req;
		req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		@(posedge clk);
		wb_req <= req;
		waited = 0;
		@(negedge clk);
		while (!wb_rsp.ack && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		if (!wb_rsp.ack) begin
			report_error("the weight store never answered with ack");
		end
		check_value(waited, 1, "cycles from stb to ack");
		rdata = wb_rsp.dat;
		@(posedge clk);
		wb_req <= '0;
	endtask

	task automatic wb_write_word(input wb_adr_t adr, input wb_dat_t dat);
		wb_dat_t unused;
		wb_transfer(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read_word(input wb_adr_t adr, output wb_dat_t dat);
		wb_transfer(1'b0, adr, '0, dat);
	endtask

	task automatic load_weights();
		for (int j = 0; j < N_WORDS; j++) begin
			wb_write_word(wb_adr_t'(j), {wref[4 * j + 3], wref[4 * j + 2], wref[4 * j + 1],
				wref[4 * j]});
		end
	endtask

	// hidden neuron n: half the dot product, clamped
	function automatic int model_hidden(input sample_t s, input int n);
		int x [N_INPUT];
		int acc;
		x[0] = $signed(s.x0);
		x[1] = $signed(s.x1);
		x[2] = $signed(s.x2);
		x[3] = $signed(s.x3);
		acc = 0;
		for (int i = 0; i < N_INPUT; i++) begin
			acc += x[i] * int'(wref[N_INPUT * n + i]);
		end
		acc = acc >>> ACT_SHIFT;
		if (acc > ACT_LIMIT) begin
			acc = ACT_LIMIT;
		end else if (acc < -ACT_LIMIT) begin
			acc = -ACT_LIMIT;
		end
		return acc;
	endfunction

	function automatic scores_t model_scores(input sample_t s);
		int h [N_HIDDEN];
		int acc [N_OUTPUT];
		scores_t r;
		for (int n = 0; n < N_HIDDEN; n++) begin
			h[n] = model_hidden(s, n);
		end
		for (int m = 0; m < N_OUTPUT; m++) begin
			acc[m] = 0;
			for (int i = 0; i < N_HIDDEN; i++) begin
				acc[m] += h[i] * int'(wref[L2_BASE + N_HIDDEN * m + i]);
			end
		end
		r.score0 = sum_t'(acc[0]);
		r.score1 = sum_t'(acc[1]);
		return r;
	endfunction

	task automatic run_inference(input sample_t s, output scores_t got);
		int cycles;
		@(posedge clk);
		sample <= s;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		cycles = 1;
		@(negedge clk);
		check_flag(busy, 1'b1, "busy in the cycle after start");
		while (!done && cycles < 100) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			report_error("done never arrived after start");
		end
		check_value(cycles, 12, "cycles from start to done");
		got = scores;
	endtask

	task automatic run_and_check(input sample_t s, input string what);
		scores_t got;
		run_inference(s, got);
		check_scores(got, model_scores(s), what);
	endtask

	task automatic test_reset_state();
		wb_dat_t d;
		@(negedge clk);
		check_flag(busy, 1'b0, "busy after reset");
		check_flag(done, 1'b0, "done after reset");
		check_flag(wb_rsp.ack, 1'b0, "ack after reset");
		check_scores(scores, '0, "scores after reset");
		for (int j = 0; j < N_WORDS; j++) begin
			wb_read_word(wb_adr_t'(j), d);
			check_word(d, '0, $sformatf("word %0d after reset", j));
		end
	endtask

	task automatic test_wb_access();
		wb_dat_t words [N_WORDS];
		wb_dat_t d;
		for (int j = 0; j < N_WORDS; j++) begin
			words[j] = $urandom();
			wb_write_word(wb_adr_t'(j), words[j]);
		end
		// out of range, must read back zero
		wb_write_word(wb_adr_t'(12), 32'hffff_ffff);
		for (int j = 0; j < N_WORDS; j++) begin
			wb_read_word(wb_adr_t'(j), d);
			check_word(d, words[j], $sformatf("read back of word %0d", j));
		end
		wb_read_word(wb_adr_t'(12), d);
		check_word(d, '0, "read of an unmapped word");
	endtask

	task automatic test_small_values();
		sample_t s;
		for (int k = 0; k < N_WEIGHTS; k++) begin
			wref[k] = weight_t'((k % 7) - 3);
		end
		load_weights();
		s = '{x3: 9'sd1, x2: 9'sd5, x1: -9'sd2, x0: 9'sd3};
		run_and_check(s, "scores with small values");
	endtask

	task automatic test_saturation();
		sample_t s;
		for (int k = 0; k < N_WEIGHTS; k++) begin
			if (k >= L2_BASE) begin
				wref[k] = weight_t'(k - 30);
			end else if (k / N_INPUT < 3) begin
				wref[k] = 8'sd100;
			end else begin
				wref[k] = -8'sd100;
			end
		end
		load_weights();
		s = '{x3: 9'sd180, x2: 9'sd240, x1: 9'sd200, x0: 9'sd255};
		run_and_check(s, "scores with saturated hidden values");
		// first three neurons clip high, the rest low
		for (int n = 0; n < N_HIDDEN; n++) begin
			check_value(int'(nn_top_i.hidden[n]), (n < 3) ? ACT_LIMIT : -ACT_LIMIT,
				$sformatf("hidden value %0d", n));
		end
	endtask

	task automatic test_start_while_busy();
		sample_t s;
		scores_t first;
		int dones;
		// mixed small weights, so the two samples end in different scores
		for (int k = 0; k < N_WEIGHTS; k++) begin
			wref[k] = weight_t'(2 * (k % 5) - 4);
		end
		load_weights();
		s = '{x3: 9'sd12, x2: -9'sd7, x1: 9'sd35, x0: -9'sd20};
		@(posedge clk);
		sample <= s;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		repeat (4) @(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		dones = 0;
		repeat (30) begin
			@(negedge clk);
			if (done) begin
				dones++;
				first = scores;
			end
		end
		check_value(dones, 1, "done pulses after a start while busy");
		check_scores(first, model_scores(s), "scores after a start while busy");
		s = '{x3: -9'sd90, x2: 9'sd64, x1: 9'sd3, x0: 9'sd41};
		run_and_check(s, "scores of the following inference");
	endtask

	task automatic test_random();
		sample_t s;
		for (int t = 0; t < 20; t++) begin
			for (int k = 0; k < N_WEIGHTS; k++) begin
				wref[k] = weight_t'($urandom());
			end
			load_weights();
			s.x0 = act_t'($urandom());
			s.x1 = act_t'($urandom());
			s.x2 = act_t'($urandom());
			s.x3 = act_t'($urandom());
			run_and_check(s, $sformatf("scores of random bank %0d", t));
		end
	endtask

	initial begin
		void'($urandom(7));
		reset = 1'b1;
		start = 1'b0;
		sample = '0;
		wb_req = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		test_reset_state();
		test_wb_access();
		test_small_values();
		test_saturation();
		test_start_while_busy();
		test_random();
		if (errors == 0 && nn_top_i.nn_chk_i.fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/nn_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module nn_chk (
	input logic clk,
	input logic reset,
	input nn_pkg::wb_req_t wb_req,
	input nn_pkg::wb_rsp_t wb_rsp,
	input logic start,
	input logic busy,
	input logic done
);

	// number of failed assertions so far
	int fail_count = 0;

	// ack only answers a live strobe
	ack_with_stb: assert property (@(posedge clk) disable iff (reset)
		wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
		else begin
			fail_count++;
			$error("ack without cyc and stb");
		end

	ack_single: assert property (@(posedge clk) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack)
		else begin
			fail_count++;
			$error("ack held longer than one cycle");
		end

	done_single: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else begin
			fail_count++;
			$error("done held longer than one cycle");
		end

	done_in_busy: assert property (@(posedge clk) disable iff (reset)
		done |-> busy)
		else begin
			fail_count++;
			$error("done while not busy");
		end

	// accepted start is cycle 0, done lands in cycle 12
	done_latency: assert property (@(posedge clk) disable iff (reset)
		start && !busy |=> !done [*11] ##1 done)
		else begin
			fail_count++;
			$error("done not exactly 12 cycles after start");
		end

endmodule

`default_nettype wire

// ==== verilog/nn_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module nn_top (
	input logic clk,
	input logic reset,
	input nn_pkg::wb_req_t wb_req,
	output nn_pkg::wb_rsp_t wb_rsp,
	input logic start,
	input nn_pkg::sample_t sample,
	output logic busy,
	output logic done,
	output nn_pkg::scores_t scores
);

	import nn_pkg::*;

	weight_bank_t weights;
	op_t op;
	logic op_valid;
	sum_t sum;
	logic sum_layer;
	neuron_t sum_neuron;
	logic sum_valid;
	act_t hidden [N_HIDDEN];
	logic hidden_ready;

	weight_store weight_store_i (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.weights(weights)
	);

	layer_decode layer_decode_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.sample(sample),
		.weights(weights),
		.hidden(hidden),
		.hidden_ready(hidden_ready),
		.done(done),
		.op(op),
		.op_valid(op_valid),
		.busy(busy)
	);

	dot_execute dot_execute_i (
		.clk(clk),
		.reset(reset),
		.op(op),
		.op_valid(op_valid),
		.sum(sum),
		.sum_layer(sum_layer),
		.sum_neuron(sum_neuron),
		.sum_valid(sum_valid)
	);

	// done also closes the sequencer's drain state
	activation_result activation_result_i (
		.clk(clk),
		.reset(reset),
		.sum(sum),
		.sum_layer(sum_layer),
		.sum_neuron(sum_neuron),
		.sum_valid(sum_valid),
		.hidden(hidden),
		.hidden_ready(hidden_ready),
		.scores(scores),
		.done(done)
	);

endmodule

`default_nettype wire

// ==== verilog/activation_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module activation_result (
	input logic clk,
	input logic reset,
	input nn_pkg::sum_t sum,
	input logic sum_layer,
	input nn_pkg::neuron_t sum_neuron,
	input logic sum_valid,
	output nn_pkg::act_t hidden [nn_pkg::N_HIDDEN],
	output logic hidden_ready,
	output nn_pkg::scores_t scores,
	output logic done
);

	import nn_pkg::*;

	sum_t shifted;
	act_t act_val;
	logic hid_wr;
	logic out_wr;

	assign hid_wr = sum_valid && !sum_layer;
	assign out_wr = sum_valid && sum_layer;

	// slope one half, then clamp
	always_comb begin
		shifted = sum >>> ACT_SHIFT;
		if (shifted > ACT_LIMIT) begin
			act_val = act_t'(ACT_LIMIT);
		end else if (shifted < -ACT_LIMIT) begin
			act_val = act_t'(-ACT_LIMIT);
		end else begin
			act_val = act_t'(shifted);
		end
	end

	always_ff @(posedge clk) begin
		if (hid_wr) begin
			hidden[sum_neuron] <= act_val;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hidden_ready <= 1'b0;
			done <= 1'b0;
			scores <= '0;
		end else begin
			hidden_ready <= hid_wr && (sum_neuron == neuron_t'(N_HIDDEN - 1));
			done <= out_wr && (sum_neuron == neuron_t'(N_OUTPUT - 1));
			// raw output sums, no activation
			if (out_wr) begin
				if (sum_neuron == '0) begin
					scores.score0 <= sum;
				end else begin
					scores.score1 <= sum;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dot_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot_execute (
	input logic clk,
	input logic reset,
	input nn_pkg::op_t op,
	input logic op_valid,
	output nn_pkg::sum_t sum,
	output logic sum_layer,
	output nn_pkg::neuron_t sum_neuron,
	output logic sum_valid
);

	import nn_pkg::*;

	sum_t acc;

	// six signed products, unused terms are zero
	always_comb begin
		acc = '0;
		for (int i = 0; i < N_HIDDEN; i++) begin
			acc = acc + $signed(op.operand[i]) * $signed(op.weight[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= op_valid;
		end
	end

	// tag travels with the sum
	always_ff @(posedge clk) begin
		if (op_valid) begin
			sum <= acc;
			sum_layer <= op.layer;
			sum_neuron <= op.neuron;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/layer_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_decode (
	input logic clk,
	input logic reset,
	input logic start,
	input nn_pkg::sample_t sample,
	input nn_pkg::weight_bank_t weights,
	input nn_pkg::act_t hidden [nn_pkg::N_HIDDEN],
	input logic hidden_ready,
	input logic done,
	output nn_pkg::op_t op,
	output logic op_valid,
	output logic busy
);

	import nn_pkg::*;

	decode_state_t state;
	neuron_t cnt;
	sample_t sample_q;
	logic accept;

	assign accept = (state == IDLE) && start;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					cnt <= '0;
					if (start) begin
						state <= LAYER1;
					end
				end
				LAYER1: begin
					if (cnt == neuron_t'(N_HIDDEN - 1)) begin
						cnt <= '0;
						state <= WAIT_HIDDEN;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				// last hidden value is written two cycles after its issue
				WAIT_HIDDEN: begin
					if (hidden_ready) begin
						state <= LAYER2;
					end
				end
				LAYER2: begin
					if (cnt == neuron_t'(N_OUTPUT - 1)) begin
						cnt <= '0;
						state <= DRAIN;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				DRAIN: begin
					if (done) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// sample held for the whole inference
	always_ff @(posedge clk) begin
		if (accept) begin
			sample_q <= sample;
		end
	end

	assign busy = (state != IDLE);
	assign op_valid = (state == LAYER1) || (state == LAYER2);

	// operand and weight select for the current neuron
	always_comb begin
		op = '0;
		op.layer = (state == LAYER2);
		op.neuron = cnt;
		if (state == LAYER2) begin
			for (int i = 0; i < N_HIDDEN; i++) begin
				op.operand[i] = hidden[i];
				op.weight[i] = weights[L2_BASE + N_HIDDEN * cnt + i];
			end
		end else begin
			op.operand[0] = sample_q.x0;
			op.operand[1] = sample_q.x1;
			op.operand[2] = sample_q.x2;
			op.operand[3] = sample_q.x3;
			for (int i = 0; i < N_INPUT; i++) begin
				op.weight[i] = weights[N_INPUT * cnt + i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/weight_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_store (
	input logic clk,
	input logic reset,
	input nn_pkg::wb_req_t wb_req,
	output nn_pkg::wb_rsp_t wb_rsp,
	output nn_pkg::weight_bank_t weights
);

	import nn_pkg::*;

	// nine words, word 0 holds weights 0 to 3
	wb_dat_t words [N_WORDS];
	logic ack_q;
	wb_dat_t dat_q;
	logic req;
	logic adr_ok;

	// new request only while no ack is out
	assign req = wb_req.cyc & wb_req.stb & ~ack_q;
	assign adr_ok = wb_req.adr < wb_adr_t'(N_WORDS);

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < N_WORDS; w++) begin
				words[w] <= '0;
			end
		end else if (req && wb_req.we && adr_ok) begin
			words[wb_req.adr] <= wb_req.dat;
		end
	end

	// read data lines up with ack
	always_ff @(posedge clk) begin
		if (req) begin
			if (adr_ok) begin
				dat_q <= words[wb_req.adr];
			end else begin
				dat_q <= '0;
			end
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = dat_q;

	// unpack words into the flat bank, low byte first
	always_comb begin
		for (int k = 0; k < N_WEIGHTS; k++) begin
			weights[k] = words[k / WEIGHTS_PER_WORD][$bits(weight_t) * (k % WEIGHTS_PER_WORD) +:
				$bits(weight_t)];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/nn_pkg.sv ====
`default_nettype none

package nn_pkg;

	// network shape
	localparam int N_INPUT = 4;
	localparam int N_HIDDEN = 6;
	localparam int N_OUTPUT = 2;

	// weight store layout
	localparam int N_WEIGHTS = 36;
	localparam int WEIGHTS_PER_WORD = 4;
	localparam int N_WORDS = N_WEIGHTS / WEIGHTS_PER_WORD;
	// first layer-2 weight, right after the 4x6 layer-1 block
	localparam int L2_BASE = 24;

	// activation: slope one half, clamped
	localparam int ACT_SHIFT = 1;
	localparam int ACT_LIMIT = 127;

	typedef logic signed [7:0] weight_t;
	typedef logic signed [8:0] act_t;
	typedef logic signed [19:0] sum_t;
	typedef logic [2:0] neuron_t;
	typedef logic [3:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;

	// x0 in the low bits
	typedef struct packed {
		act_t x3;
		act_t x2;
		act_t x1;
		act_t x0;
	} sample_t;

	// weight k at bits [8k+7:8k]
	typedef weight_t [N_WEIGHTS-1:0] weight_bank_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_adr_t adr;
		wb_dat_t dat;
	} wb_req_t;

	typedef struct packed {
		wb_dat_t dat;
		logic ack;
	} wb_rsp_t;

	// one neuron's work; layer 0 is the hidden layer
	typedef struct packed {
		logic layer;
		neuron_t neuron;
		act_t [N_HIDDEN-1:0] operand;
		weight_t [N_HIDDEN-1:0] weight;
	} op_t;

	typedef struct packed {
		sum_t score0;
		sum_t score1;
	} scores_t;

	typedef enum logic [2:0] {
		IDLE,
		LAYER1,
		WAIT_HIDDEN,
		LAYER2,
		DRAIN
	} decode_state_t;

endpackage

`default_nettype wire
